//--- verilog.f
design/uart_cmd_pkg.sv
design/baud_tick_gen.sv
design/uart_frame_tx.sv
design/uart_frame_rx.sv
design/uart_cmd_ctrl.sv
design/uart_cmd_bridge.sv
test/tb_uart_cmd_bridge.sv

//--- Makefile
# Verilator build and run for the UART command bridge.

VERILATOR ?= verilator
TOP       ?= tb_uart_cmd_bridge
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- test/tb_uart_cmd_bridge.sv
`timescale 1ns/10ps

module tb_uart_cmd_bridge
  import uart_cmd_pkg::*;
();

  localparam int CLK_DIV = 8;
  localparam int GAP_BITS = 4;
  localparam int RSP_TIMEOUT_BITS = 20;
  localparam int WAIT_LIMIT = 50 * CLK_DIV;
  localparam int FRAME_CYCLES = FRAME_BITS * CLK_DIV;

  logic      clk = 1'b0;
  logic      rst_n;
  uart_cmd_t cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      rx;
  logic      tx;
  logic      read_rdy;
  read_rsp_t read_rsp;

  int          cycle = 0;
  logic        expect_read;
  logic [31:0] lcg_state = 32'd7014;

  uart_cmd_bridge #(
    .CLK_DIV          (CLK_DIV),
    .GAP_BITS         (GAP_BITS),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read_rsp (read_rsp)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
  end

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic uart_byte_t next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  task automatic check_bit(input string name, input logic got, input logic exp);
    assert (got === exp)
    else abort($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_byte(input string name, input uart_byte_t got, input uart_byte_t exp);
    assert (got === exp)
    else abort($sformatf("error %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Read responses only after a read, always a single cycle, with cmd_rdy back.
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> expect_read)
  else abort("read_rdy pulsed while no read command was pending");
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
  else abort("read_rdy stayed high for more than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |-> cmd_rdy)
  else abort("cmd_rdy was not high together with read_rdy");

  task automatic wait_cmd_rdy();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
      abort("cmd_rdy did not return high in time");
  endtask

  // Hold keeps cmd_vld high and swaps the command after acceptance.
  task automatic start_cmd(input uart_cmd_t c, input logic hold);
    int n;
    wait_cmd_rdy();
    @(posedge clk);
    cmd_in  <= c;
    cmd_vld <= 1'b1;
    n = 0;
    @(negedge clk);
    while (cmd_rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (cmd_rdy)
      abort("command was not accepted");
    @(posedge clk);
    if (hold)
      cmd_in <= ~c;
    else
      cmd_vld <= 1'b0;
  endtask

  // Samples tx at mid-bit, counting from the start edge.
  task automatic decode_frame(output uart_byte_t b, output int start_cycle);
    int n;
    n = 0;
    @(negedge clk);
    while (tx && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (tx)
      abort("no start bit appeared on tx");
    start_cycle = cycle;
    repeat (CLK_DIV / 2) @(negedge clk);
    check_bit("tx start bit", tx, 1'b0);
    for (int i = 0; i < 8; i++)
    begin
      repeat (CLK_DIV) @(negedge clk);
      b[i] = tx;
    end
    repeat (CLK_DIV) @(negedge clk);
    check_bit("tx parity bit", tx, ^b);
    repeat (CLK_DIV) @(negedge clk);
    check_bit("tx stop bit", tx, 1'b1);
  endtask

  // Remote device reply.
  task automatic drive_rx_frame(input uart_byte_t b, input logic bad_parity,
                                input logic bad_stop);
    logic [10:0] bits;
    bits = {!bad_stop, (^b) ^ bad_parity, b, 1'b0};
    for (int i = 0; i < 11; i++)
    begin
      @(posedge clk);
      rx <= bits[i];
      repeat (CLK_DIV - 1) @(posedge clk);
    end
    @(posedge clk);
    rx <= 1'b1;
  endtask

  task automatic wait_read_rsp(output read_rsp_t r, output int at);
    int n;
    n = 0;
    @(negedge clk);
    while (!read_rdy && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!read_rdy)
      abort("no read_rdy pulse arrived");
    r = read_rsp;
    at = cycle;
  endtask

  task automatic run_write(input logic hold);
    uart_cmd_t  c;
    uart_byte_t b;
    int         s1;
    int         s2;
    c = '{is_write: 1'b1, addr: 7'(next_rand()), data: next_rand()};
    start_cmd(c, hold);
    decode_frame(b, s1);
    check_byte("tx header", b, {1'b1, c.addr});
    decode_frame(b, s2);
    check_byte("tx data", b, c.data);
    if (hold)
    begin
      @(posedge clk);
      cmd_vld <= 1'b0;
    end
    assert (s2 - s1 - FRAME_CYCLES >= GAP_BITS * CLK_DIV)
    else abort($sformatf("idle gap between write frames too short, %0d cycles",
                         s2 - s1 - FRAME_CYCLES));
    wait_cmd_rdy();
    // No further frame may follow.
    repeat (3 * FRAME_CYCLES)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
    end
  endtask

  // Mode 0 good reply, 1 bad parity, 2 low stop bit, 3 no reply.
  task automatic run_read(input int mode);
    uart_cmd_t  c;
    uart_byte_t b;
    uart_byte_t reply;
    read_rsp_t  r;
    int         s_h;
    int         t_rsp;
    c = '{is_write: 1'b0, addr: 7'(next_rand()), data: next_rand()};
    reply = next_rand();
    expect_read = 1'b1;
    start_cmd(c, 1'b0);
    decode_frame(b, s_h);
    check_byte("tx header", b, {1'b0, c.addr});
    if (mode == 3)
    begin
      wait_read_rsp(r, t_rsp);
    end
    else
    begin
      repeat (2 * CLK_DIV) @(posedge clk);
      fork
        drive_rx_frame(reply, mode == 1, mode == 2);
        wait_read_rsp(r, t_rsp);
      join
    end
    repeat (2) @(posedge clk);
    expect_read = 1'b0;
    check_bit("read_rsp.timeout", r.timeout, mode == 3);
    check_bit("read_rsp.parity_err", r.parity_err, mode == 1);
    check_bit("read_rsp.frame_err", r.frame_err, mode == 2);
    if (mode != 3)
      check_byte("read_rsp.data", r.data, reply);
    if (mode == 3)
    begin
      assert (t_rsp - s_h - FRAME_CYCLES >= RSP_TIMEOUT_BITS * CLK_DIV)
      else abort("read timeout was reported too early");
    end
  endtask

  initial
  begin
    cmd_in      = '0;
    cmd_vld     = 1'b0;
    rx          = 1'b1;
    rst_n       = 1'b0;
    expect_read = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (50)
    begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);
    end
    repeat (4) run_write(1'b0);
    repeat (4) run_read(0);
    run_read(1);
    run_read(2);
    run_read(3);
    run_write(1'b1);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- design/uart_cmd_bridge.sv
`timescale 1ns/10ps

module uart_cmd_bridge
  import uart_cmd_pkg::*;
#(
  parameter int CLK_DIV          = 434,
  parameter int GAP_BITS         = 15,
  parameter int RSP_TIMEOUT_BITS = 64
) (
  input  logic      clk,
  input  logic      rst_n,
  input  uart_cmd_t cmd_in,
  input  logic      cmd_vld,
  output logic      cmd_rdy,
  input  logic      rx,
  output logic      tx,
  output logic      read_rdy,
  output read_rsp_t read_rsp
);

  logic       bit_tick;
  logic       tx_start;
  uart_byte_t tx_byte;
  logic       tx_busy;
  logic       rx_arm;
  logic       rx_busy;
  logic       rx_done;
  rx_frame_t  rx_frame;

  uart_cmd_ctrl #(
    .GAP_BITS         (GAP_BITS),
    .RSP_TIMEOUT_BITS (RSP_TIMEOUT_BITS)
  ) ctrl0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .bit_tick (bit_tick),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_arm   (rx_arm),
    .rx_busy  (rx_busy),
    .rx_done  (rx_done),
    .rx_frame (rx_frame),
    .read_rdy (read_rdy),
    .read_rsp (read_rsp)
  );

  // Divider realigns at each frame start and free-runs otherwise.
  baud_tick_gen #(
    .CLK_DIV (CLK_DIV)
  ) baud0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .restart  (tx_start),
    .bit_tick (bit_tick)
  );

  uart_frame_tx #(
    .CLK_DIV (CLK_DIV)
  ) tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .bit_tick (bit_tick),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  uart_frame_rx #(
    .CLK_DIV (CLK_DIV)
  ) rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_busy  (rx_busy),
    .rx_done  (rx_done),
    .rx_frame (rx_frame)
  );

endmodule

//--- design/uart_cmd_ctrl.sv
`timescale 1ns/10ps

module uart_cmd_ctrl
  import uart_cmd_pkg::*;
#(
  parameter int GAP_BITS         = 15,
  parameter int RSP_TIMEOUT_BITS = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  uart_cmd_t  cmd_in,
  input  logic       cmd_vld,
  output logic       cmd_rdy,
  input  logic       bit_tick,
  output logic       tx_start,
  output uart_byte_t tx_byte,
  input  logic       tx_busy,
  output logic       rx_arm,
  input  logic       rx_busy,
  input  logic       rx_done,
  input  rx_frame_t  rx_frame,
  output logic       read_rdy,
  output read_rsp_t  read_rsp
);

  localparam int CNT_MAX = (GAP_BITS > RSP_TIMEOUT_BITS) ? GAP_BITS : RSP_TIMEOUT_BITS;
  localparam int CNT_W = (CNT_MAX > 1) ? $clog2(CNT_MAX) : 1;
  localparam logic [CNT_W-1:0] GAP_LAST = CNT_W'(GAP_BITS - 1);
  localparam logic [CNT_W-1:0] TIMEOUT_LAST = CNT_W'(RSP_TIMEOUT_BITS - 1);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HEADER,
    ST_GAP,
    ST_DATA,
    ST_WAIT_RSP,
    ST_RECV,
    ST_RESPOND
  } state_t;

  state_t           state;
  uart_cmd_t        cmd_buf;
  logic [CNT_W-1:0] tick_cnt;
  logic             tx_busy_d;
  logic             tx_end;
  logic             accept;
  logic             gap_done;
  logic             rsp_timeout;
  logic             rsp_done;

  assign accept = cmd_vld && cmd_rdy;
  assign tx_end = tx_busy_d && !tx_busy;
  assign gap_done = (state == ST_GAP) && bit_tick && (tick_cnt == GAP_LAST);
  assign rsp_timeout = (state == ST_WAIT_RSP) && !rx_busy && bit_tick
                       && (tick_cnt == TIMEOUT_LAST);
  assign rsp_done = (state == ST_RECV) && rx_done;

  // Header is the write flag followed by the address.
  assign tx_byte = (state == ST_DATA) ? cmd_buf.data : {cmd_buf.is_write, cmd_buf.addr};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= ST_IDLE;
      cmd_rdy   <= 1'b1;
      tx_start  <= 1'b0;
      rx_arm    <= 1'b0;
      read_rdy  <= 1'b0;
      tick_cnt  <= '0;
      tx_busy_d <= 1'b0;
    end
    else
    begin
      tx_start  <= 1'b0;
      read_rdy  <= 1'b0;
      tx_busy_d <= tx_busy;
      case (state)
        ST_IDLE, ST_RESPOND:
        begin
          state <= ST_IDLE;
          if (accept)
          begin
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
            state    <= ST_HEADER;
          end
        end
        ST_HEADER:
        begin
          if (tx_end)
          begin
            tick_cnt <= '0;
            if (cmd_buf.is_write)
            begin
              state <= ST_GAP;
            end
            else
            begin
              state  <= ST_WAIT_RSP;
              rx_arm <= 1'b1;
            end
          end
        end
        ST_GAP:
        begin
          if (gap_done)
          begin
            tx_start <= 1'b1;
            state    <= ST_DATA;
          end
          else if (bit_tick)
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_DATA:
        begin
          if (tx_end)
          begin
            cmd_rdy <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        ST_WAIT_RSP:
        begin
          // A start edge ends the timeout window.
          if (rx_busy)
          begin
            state <= ST_RECV;
          end
          else if (rsp_timeout)
          begin
            rx_arm   <= 1'b0;
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= ST_RESPOND;
          end
          else if (bit_tick)
          begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        ST_RECV:
        begin
          if (rsp_done)
          begin
            rx_arm   <= 1'b0;
            read_rdy <= 1'b1;
            cmd_rdy  <= 1'b1;
            state    <= ST_RESPOND;
          end
        end
        default:
        begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_buf <= cmd_in;
    end
    if (rsp_timeout)
    begin
      read_rsp <= '{data: '0, parity_err: 1'b0, frame_err: 1'b0, timeout: 1'b1};
    end
    else if (rsp_done)
    begin
      // A low stop bit is reported as a framing error.
      read_rsp <= '{data: rx_frame.data, parity_err: rx_frame.parity_err,
                    frame_err: rx_frame.stop_err, timeout: 1'b0};
    end
  end

endmodule

//--- design/uart_frame_rx.sv
`timescale 1ns/10ps

module uart_frame_rx
  import uart_cmd_pkg::*;
#(
  parameter int CLK_DIV = 434
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      rx,
  input  logic      rx_arm,
  output logic      rx_busy,
  output logic      rx_done,
  output rx_frame_t rx_frame
);

  localparam int HALF = CLK_DIV / 2;
  localparam int CNT_W = $clog2(CLK_DIV);
  localparam int IDX_W = $clog2(FRAME_BITS);
  localparam logic [IDX_W-1:0] IDX_PARITY = IDX_W'(FRAME_BITS - 2);
  localparam logic [IDX_W-1:0] IDX_STOP = IDX_W'(FRAME_BITS - 1);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_last;
  logic             start_edge;
  logic [CNT_W-1:0] cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             sample;
  logic             is_data;
  uart_byte_t       data_sr;
  logic             par_acc;

  // Two flops against metastability, a third for the edge.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_last <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_last <= rx_sync;
    end
  end

  assign start_edge = rx_arm && !rx_busy && rx_last && !rx_sync;
  assign sample = rx_busy && (cnt == '0);
  assign is_data = (bit_idx != '0) && (bit_idx < IDX_PARITY);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_busy <= 1'b0;
      rx_done <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (start_edge)
      begin
        rx_busy <= 1'b1;
        cnt     <= CNT_W'(HALF - 1);
        bit_idx <= '0;
      end
      else if (sample)
      begin
        cnt     <= CNT_W'(CLK_DIV - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == IDX_STOP)
        begin
          rx_busy <= 1'b0;
          rx_done <= 1'b1;
        end
      end
      else if (rx_busy)
      begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Data arrives LSB first.
  always_ff @(posedge clk)
  begin
    if (start_edge)
    begin
      par_acc <= 1'b0;
    end
    else if (sample && (is_data || bit_idx == IDX_PARITY))
    begin
      par_acc <= par_acc ^ rx_sync;
    end
    if (sample && is_data)
    begin
      data_sr <= {rx_sync, data_sr[7:1]};
    end
    if (sample && bit_idx == IDX_STOP)
    begin
      rx_frame.data       <= data_sr;
      rx_frame.parity_err <= par_acc;
      rx_frame.stop_err   <= !rx_sync;
    end
  end

endmodule

//--- design/uart_frame_tx.sv
`timescale 1ns/10ps

module uart_frame_tx
  import uart_cmd_pkg::*;
#(
  parameter int CLK_DIV = 434
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  uart_byte_t tx_byte,
  input  logic       bit_tick,
  output logic       tx_busy,
  output logic       tx
);

  localparam int IDX_W = $clog2(FRAME_BITS);
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(FRAME_BITS - 1);

  logic [FRAME_BITS-1:0] tx_shift;
  logic [IDX_W-1:0]      bit_idx;
  logic                  parity_bit;

  // The receiver's half-bit offset needs at least two clocks per bit.
  if (CLK_DIV < 2)
  begin : g_div_range
    $fatal(1, "uart_frame_tx: CLK_DIV must be 2 or more");
  end

  // Even parity makes the total count of ones over data and check bit even.
  assign parity_bit = ^tx_byte;

  // The line is the low bit of the shift register, so it comes straight from a flop.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_shift <= '1;
      bit_idx  <= '0;
      tx_busy  <= 1'b0;
    end
    else if (tx_start)
    begin
      tx_shift <= {STOP_BIT, parity_bit, tx_byte, START_BIT};
      bit_idx  <= '0;
      tx_busy  <= 1'b1;
    end
    else if (tx_busy && bit_tick)
    begin
      tx_shift <= {STOP_BIT, tx_shift[FRAME_BITS-1:1]};
      if (bit_idx == IDX_LAST)
      begin
        tx_busy <= 1'b0;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
      end
    end
  end

  assign tx = tx_shift[0];

endmodule

//--- design/baud_tick_gen.sv
`timescale 1ns/10ps

module baud_tick_gen #(
  parameter int CLK_DIV = 434
) (
  input  logic clk,
  input  logic rst_n,
  input  logic restart,
  output logic bit_tick
);

  localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_DIV - 1);

  logic [CNT_W-1:0] cnt;

  // Counter restarts at zero so the first tick lands CLK_DIV cycles after restart.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      cnt <= '0;
    end
    else if (restart)
    begin
      cnt <= '0;
    end
    else if (cnt == CNT_LAST)
    begin
      cnt <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;
    end
  end

  assign bit_tick = (cnt == CNT_LAST);

endmodule

//--- design/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // Host command word, bit 15 is the write flag.
  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  typedef logic [7:0] uart_byte_t;

  // One received frame with its line checks.
  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;
    logic       stop_err;
  } rx_frame_t;

  typedef struct packed {
    uart_byte_t data;
    logic       parity_err;
    logic       frame_err;
    logic       timeout;
  } read_rsp_t;

  // Start, 8 data, parity, stop.
  localparam int FRAME_BITS = 11;
  localparam logic START_BIT = 1'b0;
  localparam logic STOP_BIT = 1'b1;

endpackage
